//--- tb.f
logic/isa_pkg.sv
logic/ctrl_pkg.sv
logic/control_unit.sv
logic/alu.sv
logic/register_file.sv
logic/pc_sequencer.sv
logic/tsc_core.sv
testbench/tb_clock.sv
testbench/tsc_props.sv
testbench/tb_tsc.sv

//--- testbench/tb_tsc.sv
`timescale 1ns/10ps
`default_nettype none

module tb_tsc;

    localparam int test_cycles = 2500;
    localparam int cycle_limit = 3000;
    localparam int halt_cycle  = 2000;
    localparam logic [11:0] halt_addr = 12'hE00;

    logic        clk;
    logic        rst_n;
    logic [15:0] i_addr;
    logic [15:0] i_data;
    logic [15:0] d_addr;
    logic [15:0] d_wdata;
    logic [15:0] d_rdata;
    logic        d_read;
    logic        d_write;
    logic [15:0] output_port;
    logic        output_valid;
    logic        halted;

    logic [15:0] imem [4096];
    logic [15:0] dmem [256];
    logic [15:0] m_dmem [256];
    logic [15:0] m_regs [4];
    logic [15:0] m_pc;
    logic        m_halted;
    logic [31:0] lcg_state;
    logic        store_pending;
    logic [7:0]  store_addr;
    logic [15:0] store_data;
    int          errors;
    int          assert_fails;
    int          checked;
    int          cycle_count;

    tb_clock u_tb_clock (
        .clk   (clk),
        .rst_n (rst_n)
    );

    tsc_core tsc_core_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_addr       (i_addr),
        .i_data       (i_data),
        .d_addr       (d_addr),
        .d_wdata      (d_wdata),
        .d_rdata      (d_rdata),
        .d_read       (d_read),
        .d_write      (d_write),
        .output_port  (output_port),
        .output_valid (output_valid),
        .halted       (halted)
    );

    bind tsc_core tsc_props props_inst (
        .clk    (clk),
        .rst_n  (rst_n),
        .ctrl   (ctrl),
        .halted (halted),
        .i_addr (i_addr)
    );

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // weighted pick from the defined set, upper lcg bits only.
    function automatic logic [15:0] random_instr();
        logic [31:0] r;
        logic [3:0]  op;
        logic [5:0]  fn;
        logic [15:0] word;
        r  = lcg_next();
        op = isa_pkg::op_rtype;
        fn = {3'b000, r[26:24]};
        case (r[31:27])
            5'd14:        op = isa_pkg::op_adi;
            5'd15:        op = isa_pkg::op_ori;
            5'd16:        op = isa_pkg::op_lhi;
            5'd17, 5'd18: op = isa_pkg::op_lwd;
            5'd19, 5'd20: op = isa_pkg::op_swd;
            5'd21, 5'd22: fn = isa_pkg::func_wwd;
            5'd23:        op = isa_pkg::op_bne;
            5'd24:        op = isa_pkg::op_beq;
            5'd25:        op = isa_pkg::op_bgz;
            5'd26:        op = isa_pkg::op_blz;
            5'd27:        op = isa_pkg::op_jmp;
            5'd28:        op = isa_pkg::op_jal;
            5'd29:        fn = isa_pkg::func_jpr;
            5'd30:        fn = isa_pkg::func_jrl;
            // hlt slot, taken as add here.
            5'd31:        fn = isa_pkg::func_add;
            default:      ;
        endcase
        word = {op, r[23:12]};
        if (op == isa_pkg::op_rtype) begin
            word[5:0] = fn;
        end
        return word;
    endfunction

    task automatic report_mismatch(input string name, input logic [15:0] expected,
                                   input logic [15:0] actual);
        errors++;
        $display("** Error at %0d ns: %s expected %h, got %h", $time, name, expected, actual);
    endtask

    // compare this cycle's outputs, then retire one instruction in the model.
    task automatic compare_and_step();
        isa_pkg::instr_t ins;
        logic [15:0] rs_v;
        logic [15:0] rt_v;
        logic [15:0] sx;
        logic [15:0] addr;
        logic [15:0] res;
        logic [15:0] next_pc;
        logic [1:0]  wa;
        logic        wr;
        logic        exp_dw;
        logic        exp_dr;
        logic        exp_ov;
        logic        halt_now;
        ins      = isa_pkg::instr_t'(imem[m_pc[11:0]]);
        rs_v     = m_regs[ins.rs];
        rt_v     = m_regs[ins.rt];
        sx       = {{8{ins[7]}}, ins[7:0]};
        addr     = rs_v + sx;
        res      = 16'h0000;
        next_pc  = m_pc + 16'd1;
        wa       = ins.rt;
        wr       = 1'b0;
        exp_dw   = 1'b0;
        exp_dr   = 1'b0;
        exp_ov   = 1'b0;
        halt_now = 1'b0;
        checked++;
        case (ins.opcode)
            isa_pkg::op_bne: if (rs_v != rt_v) next_pc = m_pc + 16'd1 + sx;
            isa_pkg::op_beq: if (rs_v == rt_v) next_pc = m_pc + 16'd1 + sx;
            isa_pkg::op_bgz: if ($signed(rs_v) > 0) next_pc = m_pc + 16'd1 + sx;
            isa_pkg::op_blz: if ($signed(rs_v) < 0) next_pc = m_pc + 16'd1 + sx;
            isa_pkg::op_adi: begin
                wr  = 1'b1;
                res = rs_v + sx;
            end
            isa_pkg::op_ori: begin
                wr  = 1'b1;
                res = rs_v | {8'h00, ins[7:0]};
            end
            isa_pkg::op_lhi: begin
                wr  = 1'b1;
                res = {ins[7:0], 8'h00};
            end
            isa_pkg::op_lwd: begin
                wr     = 1'b1;
                exp_dr = 1'b1;
                res    = m_dmem[addr[7:0]];
            end
            isa_pkg::op_swd: exp_dw = 1'b1;
            isa_pkg::op_jmp: next_pc = {m_pc[15:12], ins[11:0]};
            isa_pkg::op_jal: begin
                wr      = 1'b1;
                wa      = 2'd2;
                res     = m_pc + 16'd1;
                next_pc = {m_pc[15:12], ins[11:0]};
            end
            isa_pkg::op_rtype: begin
                wa = ins.rd;
                wr = (ins.func <= isa_pkg::func_shr);
                case (ins.func)
                    isa_pkg::func_add: res = rs_v + rt_v;
                    isa_pkg::func_sub: res = rs_v - rt_v;
                    isa_pkg::func_and: res = rs_v & rt_v;
                    isa_pkg::func_orr: res = rs_v | rt_v;
                    isa_pkg::func_not: res = ~rs_v;
                    isa_pkg::func_tcp: res = 16'd0 - rs_v;
                    isa_pkg::func_shl: res = rs_v << 1;
                    isa_pkg::func_shr: res = $unsigned($signed(rs_v) >>> 1);
                    isa_pkg::func_jpr: next_pc = rs_v;
                    isa_pkg::func_jrl: begin
                        wr      = 1'b1;
                        wa      = 2'd2;
                        res     = m_pc + 16'd1;
                        next_pc = rs_v;
                    end
                    isa_pkg::func_wwd: exp_ov = 1'b1;
                    isa_pkg::func_hlt: halt_now = 1'b1;
                    default: ;
                endcase
            end
            default: ;
        endcase
        if (m_halted) begin
            exp_dw = 1'b0;
            exp_dr = 1'b0;
            exp_ov = 1'b0;
        end
        if (i_addr !== m_pc) report_mismatch("i_addr", m_pc, i_addr);
        if (halted !== m_halted) report_mismatch("halted", m_halted, halted);
        if (d_write !== exp_dw) report_mismatch("d_write", exp_dw, d_write);
        if (d_read !== exp_dr) report_mismatch("d_read", exp_dr, d_read);
        if (output_valid !== exp_ov) report_mismatch("output_valid", exp_ov, output_valid);
        if ((exp_dw || exp_dr) && d_addr !== addr) report_mismatch("d_addr", addr, d_addr);
        if (exp_dw && d_wdata !== rt_v) report_mismatch("d_wdata", rt_v, d_wdata);
        if (exp_ov && output_port !== rs_v) report_mismatch("output_port", rs_v, output_port);
        // the tb memory follows the DUT's own store strobe.
        if (d_write === 1'b1) begin
            store_pending = 1'b1;
            store_addr    = d_addr[7:0];
            store_data    = d_wdata;
        end
        if (!m_halted) begin
            if (wr) m_regs[wa] = res;
            if (exp_dw) m_dmem[addr[7:0]] = rt_v;
            if (halt_now) begin
                m_halted = 1'b1;
            end else begin
                m_pc = next_pc;
            end
        end
    endtask

    initial begin
        i_data        = 16'h0000;
        d_rdata       = 16'h0000;
        errors        = 0;
        assert_fails  = 0;
        checked       = 0;
        store_pending = 1'b0;
        store_addr    = 8'h00;
        store_data    = 16'h0000;
        lcg_state     = 32'h656e_ee24;
        m_pc          = 16'h0000;
        m_halted      = 1'b0;
        for (int i = 0; i < 4; i++) begin
            m_regs[i] = 16'h0000;
        end
        for (int i = 0; i < 4096; i++) begin
            imem[i] = random_instr();
        end
        imem[halt_addr] = {isa_pkg::op_rtype, 6'b000000, isa_pkg::func_hlt};
        for (int i = 0; i < 256; i++) begin
            dmem[i]   = 16'(lcg_next() >> 16);
            m_dmem[i] = dmem[i];
        end
        for (int cycle = 0; cycle < test_cycles; cycle++) begin
            @(posedge clk);
            if (store_pending) begin
                dmem[store_addr] = store_data;
                store_pending    = 1'b0;
            end
            // late in the run the program is sent to the hlt.
            if (cycle == halt_cycle && !m_halted && m_pc[11:0] != halt_addr) begin
                imem[m_pc[11:0]] = {isa_pkg::op_jmp, halt_addr};
            end
            #1;
            i_data = imem[i_addr[11:0]];
            // data read answers the address decoded from the new instruction.
            #1;
            d_rdata = dmem[d_addr[7:0]];
            @(negedge clk);
            if (rst_n) begin
                compare_and_step();
            end
        end
        assert_fails = tsc_core_inst.props_inst.fail_count;
        $display("cycles checked %0d, errors %0d, assertion failures %0d",
                 checked, errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    initial begin
        cycle_count = 0;
        forever begin
            @(posedge clk);
            cycle_count++;
            if (cycle_count >= cycle_limit) begin
                $display("timeout: run did not finish within %0d cycles", cycle_limit);
                $display("*** FAILED ***");
                $finish;
            end
        end
    end

endmodule

`default_nettype wire

//--- testbench/tsc_props.sv
`timescale 1ns/10ps
`default_nettype none

module tsc_props (
    input logic                             clk,
    input logic                             rst_n,
    input ctrl_pkg::ctrl_t                  ctrl,
    input logic                             halted,
    input logic [isa_pkg::word_size-1:0]    i_addr
);

    int fail_count = 0;

    load_writes_back: assert property (@(posedge clk) disable iff (!rst_n)
        ctrl.mem_read |-> ctrl.mem_to_reg)
        else begin
            fail_count++;
            $error("mem_read without mem_to_reg");
        end

    store_no_reg_write: assert property (@(posedge clk) disable iff (!rst_n)
        !(ctrl.mem_write && ctrl.reg_write))
        else begin
            fail_count++;
            $error("mem_write together with reg_write");
        end

    branch_no_jump: assert property (@(posedge clk) disable iff (!rst_n)
        ctrl.branch |-> (ctrl.jump == ctrl_pkg::jump_none))
        else begin
            fail_count++;
            $error("branch together with a jump");
        end

    // a halted core keeps fetching the same address.
    halt_holds_pc: assert property (@(posedge clk) disable iff (!rst_n)
        halted |=> $stable(i_addr))
        else begin
            fail_count++;
            $error("i_addr moved while halted");
        end

endmodule

`default_nettype wire

//--- testbench/tb_clock.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock (
    output logic clk,
    output logic rst_n
);

    // 40 ns period.
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // reset is held over three rising edges, released just after the third.
    initial begin
        rst_n = 1'b0;
        repeat (3) @(posedge clk);
        #1 rst_n = 1'b1;
    end

endmodule

`default_nettype wire

//--- logic/tsc_core.sv
`timescale 1ns/10ps
`default_nettype none

module tsc_core (
    input  logic                             clk,
    input  logic                             rst_n,
    output logic [isa_pkg::word_size-1:0]    i_addr,
    input  logic [isa_pkg::word_size-1:0]    i_data,
    output logic [isa_pkg::word_size-1:0]    d_addr,
    output logic [isa_pkg::word_size-1:0]    d_wdata,
    input  logic [isa_pkg::word_size-1:0]    d_rdata,
    output logic                             d_read,
    output logic                             d_write,
    output logic [isa_pkg::word_size-1:0]    output_port,
    output logic                             output_valid,
    output logic                             halted
);

    isa_pkg::instr_t                 instr;
    ctrl_pkg::ctrl_t                 ctrl;
    logic [7:0]                      imm;
    logic [isa_pkg::word_size-1:0]   imm_ext;
    logic [isa_pkg::word_size-1:0]   rs_data;
    logic [isa_pkg::word_size-1:0]   rt_data;
    logic [isa_pkg::word_size-1:0]   alu_b;
    logic [isa_pkg::word_size-1:0]   alu_result;
    logic                            taken;
    logic [isa_pkg::word_size-1:0]   pc_plus_one;
    logic [1:0]                      wr_addr;
    logic [isa_pkg::word_size-1:0]   wr_data;
    logic                            wr_en;

    assign instr = isa_pkg::instr_t'(i_data);

    control_unit u_control_unit (
        .instr (instr),
        .ctrl  (ctrl)
    );

    assign imm     = isa_pkg::imm_of(instr);
    assign imm_ext = ctrl.zero_extended ? {{(isa_pkg::word_size-8){1'b0}}, imm}
                                        : {{(isa_pkg::word_size-8){imm[7]}}, imm};
    assign alu_b   = ctrl.alu_src ? imm_ext : rt_data;

    // write port target and source.
    always_comb begin
        if (ctrl.pc_to_reg) begin
            wr_addr = isa_pkg::link_reg;
        end else if (ctrl.rt_write) begin
            wr_addr = instr.rt;
        end else begin
            wr_addr = instr.rd;
        end
    end

    always_comb begin
        if (ctrl.pc_to_reg) begin
            wr_data = pc_plus_one;
        end else if (ctrl.mem_to_reg) begin
            wr_data = d_rdata;
        end else begin
            wr_data = alu_result;
        end
    end

    // nothing retires once the core has halted.
    assign wr_en        = ctrl.reg_write && !halted;
    assign d_read       = ctrl.mem_read && !halted;
    assign d_write      = ctrl.mem_write && !halted;
    assign output_valid = ctrl.out_write && !halted;

    register_file u_register_file (
        .clk     (clk),
        .rst_n   (rst_n),
        .rs_addr (instr.rs),
        .rt_addr (instr.rt),
        .wr_addr (wr_addr),
        .wr_en   (wr_en),
        .wr_data (wr_data),
        .rs_data (rs_data),
        .rt_data (rt_data)
    );

    alu u_alu (
        .op     (ctrl.alu_op),
        .cond   (ctrl.cond),
        .a      (rs_data),
        .b      (alu_b),
        .cmp    (rt_data),
        .result (alu_result),
        .taken  (taken)
    );

    pc_sequencer u_pc_sequencer (
        .clk         (clk),
        .rst_n       (rst_n),
        .jump        (ctrl.jump),
        .branch      (ctrl.branch),
        .taken       (taken),
        .halt        (ctrl.halt),
        .target      (isa_pkg::target_of(instr)),
        .offset      (imm),
        .jump_reg    (rs_data),
        .pc          (i_addr),
        .pc_plus_one (pc_plus_one),
        .halted      (halted)
    );

    assign d_addr      = alu_result;
    assign d_wdata     = rt_data;
    assign output_port = rs_data;

endmodule

`default_nettype wire

//--- logic/pc_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

module pc_sequencer (
    input  logic                             clk,
    input  logic                             rst_n,
    input  ctrl_pkg::jump_sel_t              jump,
    input  logic                             branch,
    input  logic                             taken,
    input  logic                             halt,
    input  logic [11:0]                      target,
    input  logic [7:0]                       offset,
    input  logic [isa_pkg::word_size-1:0]    jump_reg,
    output logic [isa_pkg::word_size-1:0]    pc,
    output logic [isa_pkg::word_size-1:0]    pc_plus_one,
    output logic                             halted
);

    logic [isa_pkg::word_size-1:0] branch_target;
    logic [isa_pkg::word_size-1:0] next_pc;

    assign pc_plus_one   = pc + 1'b1;
    assign branch_target = pc_plus_one + {{(isa_pkg::word_size-8){offset[7]}}, offset};

    always_comb begin
        case (jump)
            // jump stays inside the current 4k page.
            ctrl_pkg::jump_target:   next_pc = {pc[isa_pkg::word_size-1:12], target};
            ctrl_pkg::jump_register: next_pc = jump_reg;
            default:                 next_pc = (branch && taken) ? branch_target : pc_plus_one;
        endcase
    end

    // hlt parks the pc on itself until reset.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc     <= '0;
            halted <= 1'b0;
        end else if (!halted) begin
            if (halt) begin
                halted <= 1'b1;
            end else begin
                pc <= next_pc;
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/register_file.sv
`timescale 1ns/10ps
`default_nettype none

module register_file (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic [1:0]                       rs_addr,
    input  logic [1:0]                       rt_addr,
    input  logic [1:0]                       wr_addr,
    input  logic                             wr_en,
    input  logic [isa_pkg::word_size-1:0]    wr_data,
    output logic [isa_pkg::word_size-1:0]    rs_data,
    output logic [isa_pkg::word_size-1:0]    rt_data
);

    logic [isa_pkg::word_size-1:0] regs [4];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 4; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // no bypass, a same-cycle read sees the old value.
    assign rs_data = regs[rs_addr];
    assign rt_data = regs[rt_addr];

endmodule

`default_nettype wire

//--- logic/alu.sv
`timescale 1ns/10ps
`default_nettype none

module alu (
    input  ctrl_pkg::alu_op_t                op,
    input  ctrl_pkg::cond_t                  cond,
    input  logic [isa_pkg::word_size-1:0]    a,
    input  logic [isa_pkg::word_size-1:0]    b,
    input  logic [isa_pkg::word_size-1:0]    cmp,
    output logic [isa_pkg::word_size-1:0]    result,
    output logic                             taken
);

    always_comb begin
        case (op)
            ctrl_pkg::alu_add:  result = a + b;
            ctrl_pkg::alu_sub:  result = a - b;
            ctrl_pkg::alu_and:  result = a & b;
            ctrl_pkg::alu_or:   result = a | b;
            ctrl_pkg::alu_not:  result = ~a;
            ctrl_pkg::alu_tcp:  result = ~a + 1'b1;
            ctrl_pkg::alu_shl:  result = {a[isa_pkg::word_size-2:0], 1'b0};
            // arithmetic, sign bit is kept.
            ctrl_pkg::alu_shr:  result = {a[isa_pkg::word_size-1], a[isa_pkg::word_size-1:1]};
            ctrl_pkg::alu_lhi:  result = {b[7:0], 8'h00};
            ctrl_pkg::alu_pass: result = a;
            default:            result = a;
        endcase
    end

    // branch condition on rs, with rt for the compare forms.
    always_comb begin
        case (cond)
            ctrl_pkg::cond_ne: taken = (a != cmp);
            ctrl_pkg::cond_eq: taken = (a == cmp);
            ctrl_pkg::cond_gz: taken = !a[isa_pkg::word_size-1] && (a != '0);
            default:           taken = a[isa_pkg::word_size-1];
        endcase
    end

endmodule

`default_nettype wire

//--- logic/control_unit.sv
`timescale 1ns/10ps
`default_nettype none

module control_unit (
    input  isa_pkg::instr_t instr,
    output ctrl_pkg::ctrl_t ctrl
);

    always_comb begin
        ctrl = ctrl_pkg::ctrl_idle;
        case (instr.opcode)
            isa_pkg::op_rtype: begin
                case (instr.func)
                    isa_pkg::func_add: begin
                        ctrl.reg_write = 1'b1;
                        ctrl.alu_op    = ctrl_pkg::alu_add;
                    end
                    isa_pkg::func_sub: begin
                        ctrl.reg_write = 1'b1;
                        ctrl.alu_op    = ctrl_pkg::alu_sub;
                    end
                    isa_pkg::func_and: begin
                        ctrl.reg_write = 1'b1;
                        ctrl.alu_op    = ctrl_pkg::alu_and;
                    end
                    isa_pkg::func_orr: begin
                        ctrl.reg_write = 1'b1;
                        ctrl.alu_op    = ctrl_pkg::alu_or;
                    end
                    isa_pkg::func_not: begin
                        ctrl.reg_write = 1'b1;
                        ctrl.alu_op    = ctrl_pkg::alu_not;
                    end
                    isa_pkg::func_tcp: begin
                        ctrl.reg_write = 1'b1;
                        ctrl.alu_op    = ctrl_pkg::alu_tcp;
                    end
                    isa_pkg::func_shl: begin
                        ctrl.reg_write = 1'b1;
                        ctrl.alu_op    = ctrl_pkg::alu_shl;
                    end
                    isa_pkg::func_shr: begin
                        ctrl.reg_write = 1'b1;
                        ctrl.alu_op    = ctrl_pkg::alu_shr;
                    end
                    isa_pkg::func_jpr: begin
                        ctrl.jump = ctrl_pkg::jump_register;
                    end
                    isa_pkg::func_jrl: begin
                        ctrl.reg_write = 1'b1;
                        ctrl.jump      = ctrl_pkg::jump_register;
                        ctrl.pc_to_reg = 1'b1;
                    end
                    isa_pkg::func_wwd: ctrl.out_write = 1'b1;
                    isa_pkg::func_hlt: ctrl.halt = 1'b1;
                    default: ctrl = ctrl_pkg::ctrl_idle;
                endcase
            end
            isa_pkg::op_adi, isa_pkg::op_lhi: begin
                ctrl.alu_src   = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.rt_write  = 1'b1;
                ctrl.alu_op    = (instr.opcode == isa_pkg::op_lhi) ?
                                 ctrl_pkg::alu_lhi : ctrl_pkg::alu_add;
            end
            isa_pkg::op_ori: begin
                ctrl.alu_src       = 1'b1;
                ctrl.reg_write     = 1'b1;
                ctrl.rt_write      = 1'b1;
                ctrl.zero_extended = 1'b1;
                ctrl.alu_op        = ctrl_pkg::alu_or;
            end
            isa_pkg::op_lwd: begin
                ctrl.alu_src    = 1'b1;
                ctrl.reg_write  = 1'b1;
                ctrl.rt_write   = 1'b1;
                ctrl.mem_read   = 1'b1;
                ctrl.mem_to_reg = 1'b1;
                ctrl.alu_op     = ctrl_pkg::alu_add;
            end
            isa_pkg::op_swd: begin
                ctrl.alu_src   = 1'b1;
                ctrl.mem_write = 1'b1;
                ctrl.alu_op    = ctrl_pkg::alu_add;
            end
            isa_pkg::op_bne, isa_pkg::op_beq: begin
                ctrl.branch = 1'b1;
                ctrl.cond   = (instr.opcode == isa_pkg::op_bne) ?
                              ctrl_pkg::cond_ne : ctrl_pkg::cond_eq;
            end
            isa_pkg::op_bgz, isa_pkg::op_blz: begin
                ctrl.alu_src = 1'b1;
                ctrl.branch  = 1'b1;
                ctrl.cond    = (instr.opcode == isa_pkg::op_bgz) ?
                               ctrl_pkg::cond_gz : ctrl_pkg::cond_lz;
            end
            isa_pkg::op_jmp: ctrl.jump = ctrl_pkg::jump_target;
            isa_pkg::op_jal: begin
                ctrl.reg_write = 1'b1;
                ctrl.jump      = ctrl_pkg::jump_target;
                ctrl.pc_to_reg = 1'b1;
            end
            default: ctrl = ctrl_pkg::ctrl_idle;
        endcase
    end

endmodule

`default_nettype wire

//--- logic/ctrl_pkg.sv
`default_nettype none

package ctrl_pkg;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_not,
        alu_tcp,
        alu_shl,
        alu_shr,
        alu_lhi,
        alu_pass
    } alu_op_t;

    // source of a non-sequential pc.
    typedef enum logic [1:0] {
        jump_none,
        jump_target,
        jump_register
    } jump_sel_t;

    typedef enum logic [1:0] {
        cond_ne,
        cond_eq,
        cond_gz,
        cond_lz
    } cond_t;

    typedef struct packed {
        logic      alu_src;
        logic      reg_write;
        logic      mem_read;
        logic      mem_to_reg;
        logic      mem_write;
        jump_sel_t jump;
        logic      branch;
        cond_t     cond;
        logic      pc_to_reg;
        logic      rt_write;
        logic      zero_extended;
        logic      out_write;
        logic      halt;
        alu_op_t   alu_op;
    } ctrl_t;

    // control word with nothing active.
    localparam ctrl_t ctrl_idle = '{
        alu_src:       1'b0,
        reg_write:     1'b0,
        mem_read:      1'b0,
        mem_to_reg:    1'b0,
        mem_write:     1'b0,
        jump:          jump_none,
        branch:        1'b0,
        cond:          cond_ne,
        pc_to_reg:     1'b0,
        rt_write:      1'b0,
        zero_extended: 1'b0,
        out_write:     1'b0,
        halt:          1'b0,
        alu_op:        alu_pass
    };

endpackage

`default_nettype wire

//--- logic/isa_pkg.sv
`default_nettype none

package isa_pkg;

    // data, address and instruction width.
    localparam int word_size = 16;

    // opcodes, top nibble of the instruction.
    localparam logic [3:0] op_bne   = 4'd0;
    localparam logic [3:0] op_beq   = 4'd1;
    localparam logic [3:0] op_bgz   = 4'd2;
    localparam logic [3:0] op_blz   = 4'd3;
    localparam logic [3:0] op_adi   = 4'd4;
    localparam logic [3:0] op_ori   = 4'd5;
    localparam logic [3:0] op_lhi   = 4'd6;
    localparam logic [3:0] op_lwd   = 4'd7;
    localparam logic [3:0] op_swd   = 4'd8;
    localparam logic [3:0] op_jmp   = 4'd9;
    localparam logic [3:0] op_jal   = 4'd10;
    localparam logic [3:0] op_rtype = 4'd15;

    // function codes, only meaningful under op_rtype.
    localparam logic [5:0] func_add = 6'd0;
    localparam logic [5:0] func_sub = 6'd1;
    localparam logic [5:0] func_and = 6'd2;
    localparam logic [5:0] func_orr = 6'd3;
    localparam logic [5:0] func_not = 6'd4;
    localparam logic [5:0] func_tcp = 6'd5;
    localparam logic [5:0] func_shl = 6'd6;
    localparam logic [5:0] func_shr = 6'd7;
    localparam logic [5:0] func_jpr = 6'd25;
    localparam logic [5:0] func_jrl = 6'd26;
    localparam logic [5:0] func_wwd = 6'd28;
    localparam logic [5:0] func_hlt = 6'd29;

    // return address register for jal and jrl.
    localparam logic [1:0] link_reg = 2'd2;

    typedef struct packed {
        logic [3:0] opcode;
        logic [1:0] rs;
        logic [1:0] rt;
        logic [1:0] rd;
        logic [5:0] func;
    } instr_t;

    // immediate overlaps rd and func.
    function automatic logic [7:0] imm_of(instr_t instr);
        return {instr.rd, instr.func};
    endfunction

    // jump target is everything below the opcode.
    function automatic logic [11:0] target_of(instr_t instr);
        return {instr.rs, instr.rt, instr.rd, instr.func};
    endfunction

endpackage

`default_nettype wire
